/* rtl/axi_perf_pkg.sv */
`default_nettype none

package axi_perf_pkg;

  localparam int unsigned AXI_ADDR_W = 20;
  localparam int unsigned AXI_DATA_W = 16;
  localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;
  localparam int unsigned AXI_ID_W   = 4;
  // the id bits above these carry the generator index
  localparam int unsigned GEN_ID_W   = AXI_ID_W - 1;
  localparam int unsigned STAT_W     = 32;

  localparam logic [1:0] AXI_BURST_INCR = 2'd1;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'd0;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_ID_W-1:0]   id;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] base_addr;
    logic [7:0]            beats;
    // stride is in bytes
    logic [AXI_ADDR_W-1:0] stride;
    logic [15:0]           num_bursts;
  } burst_cfg_t;

  typedef struct packed {
    logic [STAT_W-1:0] aw_count;
    logic [STAT_W-1:0] w_count;
    logic [STAT_W-1:0] b_count;
    logic [STAT_W-1:0] b_err_count;
    logic [STAT_W-1:0] active_cycles;
  } wr_stats_t;

  // 128 data words of stride at the default width
  localparam burst_cfg_t CFG_RESET = '{
    base_addr:  '0,
    beats:      8'd64,
    stride:     AXI_ADDR_W'(256),
    num_bursts: 16'd16
  };

endpackage

`default_nettype wire

/* rtl/axi_perf_ctrl.sv */
`default_nettype none

module axi_perf_ctrl #(
  parameter int unsigned NUM_GEN = 2,
  localparam int unsigned SEL_W = (NUM_GEN > 1) ? $clog2(NUM_GEN) : 1
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   cfg_we_i,
  input  logic [SEL_W-1:0]                       cfg_gen_i,
  input  axi_perf_pkg::burst_cfg_t               cfg_i,
  input  logic                                   start_i,
  input  logic [NUM_GEN-1:0]                     gen_busy_i,
  output logic [NUM_GEN-1:0]                     gen_start_o,
  output axi_perf_pkg::burst_cfg_t [NUM_GEN-1:0] gen_cfg_o,
  output logic                                   stat_clear_o,
  output logic                                   busy_o,
  output logic                                   done_o
);
  import axi_perf_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_WAIT,
    ST_DONE
  } state_t;

  state_t                   state_q;
  state_t                   state_d;
  burst_cfg_t [NUM_GEN-1:0] cfg_q;
  logic                     done_q;
  logic                     start_ok;

  assign busy_o       = (state_q == ST_RUN) || (state_q == ST_WAIT);
  assign start_ok     = start_i && !busy_o;
  assign gen_start_o  = {NUM_GEN{state_q == ST_RUN}};
  assign stat_clear_o = (state_q == ST_RUN);
  assign gen_cfg_o    = cfg_q;
  assign done_o       = done_q;

  // ---------------------------------------------------------
  // configuration registers, frozen while a run is busy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int g = 0; g < NUM_GEN; g++) begin
        cfg_q[g] <= CFG_RESET;
      end
    end else if (cfg_we_i && !busy_o) begin
      for (int g = 0; g < NUM_GEN; g++) begin
        if (cfg_gen_i == SEL_W'(g)) begin
          cfg_q[g] <= cfg_i;
        end
      end
    end
  end

  // ---------------------------------------------------------
  // run sequencer
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_RUN;
        end
      end
      // generators see their start pulse here
      ST_RUN: state_d = ST_WAIT;
      ST_WAIT: begin
        if (gen_busy_i == '0) begin
          state_d = ST_DONE;
        end
      end
      ST_DONE: state_d = start_i ? ST_RUN : ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        done_q <= 1'b0;
      end else if (state_q == ST_DONE) begin
        done_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/axi_perf_wr.sv */
`default_nettype none

module axi_perf_wr (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start_i,
  input  axi_perf_pkg::burst_cfg_t cfg_i,
  output logic                     busy_o,
  output logic                     awvalid_o,
  output axi_perf_pkg::axi_aw_t    aw_o,
  input  logic                     awready_i,
  output logic                     wvalid_o,
  output axi_perf_pkg::axi_w_t     w_o,
  input  logic                     wready_i,
  input  logic                     bvalid_i,
  input  axi_perf_pkg::axi_b_t     b_i,
  output logic                     bready_o
);
  import axi_perf_pkg::*;

  localparam logic [2:0]          AW_SIZE = 3'($clog2(AXI_STRB_W));
  localparam logic [GEN_ID_W-1:0] GEN_ID  = '0;

  burst_cfg_t            cfg_q;
  logic                  busy_q;
  logic [15:0]           aw_cnt_q;
  logic [15:0]           w_cnt_q;
  logic [15:0]           b_cnt_q;
  logic [15:0]           b_cnt_next;
  logic [7:0]            beat_q;
  logic [AXI_ADDR_W-1:0] aw_addr_q;
  logic [AXI_ADDR_W-1:0] w_base_q;
  logic [AXI_ADDR_W-1:0] w_addr_q;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;
  logic                  w_last;

  assign aw_fire    = awvalid_o && awready_i;
  assign w_fire     = wvalid_o && wready_i;
  // only responses carrying our own id are counted
  assign b_fire     = bvalid_i && bready_o && (b_i.id[GEN_ID_W-1:0] == GEN_ID);
  assign w_last     = (beat_q == cfg_q.beats - 8'd1);
  assign b_cnt_next = b_cnt_q + 16'(b_fire);

  assign busy_o    = busy_q;
  assign bready_o  = busy_q;
  assign awvalid_o = busy_q && (aw_cnt_q != cfg_q.num_bursts);
  // a burst's data only goes out once its address was accepted
  assign wvalid_o  = busy_q && (w_cnt_q != aw_cnt_q);

  always_comb begin
    aw_o.addr  = aw_addr_q;
    aw_o.id    = AXI_ID_W'(GEN_ID);
    aw_o.len   = cfg_q.beats - 8'd1;
    aw_o.size  = AW_SIZE;
    aw_o.burst = AXI_BURST_INCR;
    w_o.data   = AXI_DATA_W'(w_addr_q);
    w_o.strb   = '1;
    w_o.last   = w_last;
  end

  // ---------------------------------------------------------
  // burst, beat and response counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      aw_cnt_q <= '0;
      w_cnt_q  <= '0;
      b_cnt_q  <= '0;
      beat_q   <= '0;
    end else if (start_i && !busy_q) begin
      busy_q   <= 1'b1;
      aw_cnt_q <= '0;
      w_cnt_q  <= '0;
      b_cnt_q  <= '0;
      beat_q   <= '0;
    end else if (busy_q) begin
      if (aw_fire) begin
        aw_cnt_q <= aw_cnt_q + 16'd1;
      end
      if (w_fire) begin
        if (w_last) begin
          beat_q  <= '0;
          w_cnt_q <= w_cnt_q + 16'd1;
        end else begin
          beat_q <= beat_q + 8'd1;
        end
      end
      b_cnt_q <= b_cnt_next;
      // also ends a run programmed with zero bursts
      if (b_cnt_next == cfg_q.num_bursts) begin
        busy_q <= 1'b0;
      end
    end
  end

  // ---------------------------------------------------------
  // address pattern
  always_ff @(posedge clk) begin
    if (start_i && !busy_q) begin
      cfg_q     <= cfg_i;
      aw_addr_q <= cfg_i.base_addr;
      w_base_q  <= cfg_i.base_addr;
      w_addr_q  <= cfg_i.base_addr;
    end else begin
      if (aw_fire) begin
        aw_addr_q <= aw_addr_q + cfg_q.stride;
      end
      if (w_fire) begin
        if (w_last) begin
          w_base_q <= w_base_q + cfg_q.stride;
          w_addr_q <= w_base_q + cfg_q.stride;
        end else begin
          w_addr_q <= w_addr_q + AXI_ADDR_W'(AXI_STRB_W);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/axi_perf_wr_arb.sv */
`default_nettype none

module axi_perf_wr_arb #(
  parameter int unsigned NUM_GEN = 2
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [NUM_GEN-1:0]                  s_awvalid_i,
  input  axi_perf_pkg::axi_aw_t [NUM_GEN-1:0] s_aw_i,
  output logic [NUM_GEN-1:0]                  s_awready_o,
  input  logic [NUM_GEN-1:0]                  s_wvalid_i,
  input  axi_perf_pkg::axi_w_t [NUM_GEN-1:0]  s_w_i,
  output logic [NUM_GEN-1:0]                  s_wready_o,
  output logic [NUM_GEN-1:0]                  s_bvalid_o,
  output axi_perf_pkg::axi_b_t [NUM_GEN-1:0]  s_b_o,
  input  logic [NUM_GEN-1:0]                  s_bready_i,
  output logic                                m_awvalid_o,
  output axi_perf_pkg::axi_aw_t               m_aw_o,
  input  logic                                m_awready_i,
  output logic                                m_wvalid_o,
  output axi_perf_pkg::axi_w_t                m_w_o,
  input  logic                                m_wready_i,
  input  logic                                m_bvalid_i,
  input  axi_perf_pkg::axi_b_t                m_b_i,
  output logic                                m_bready_o
);
  import axi_perf_pkg::*;

  localparam int unsigned IDX_W   = AXI_ID_W - GEN_ID_W;
  localparam int unsigned Q_DEPTH = 4;
  localparam int unsigned QP_W    = $clog2(Q_DEPTH);
  localparam int unsigned CNT_W   = QP_W + 1;

  logic [IDX_W-1:0] rr_q;
  logic [IDX_W-1:0] pick;
  logic [IDX_W-1:0] grant;
  logic [IDX_W-1:0] hold_idx_q;
  logic             hold_q;
  logic             aw_fire;
  logic [IDX_W-1:0] q_mem [Q_DEPTH];
  logic [QP_W-1:0]  wr_ptr_q;
  logic [QP_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             q_full;
  logic             q_empty;
  logic [IDX_W-1:0] head;
  logic             w_pop;
  logic [IDX_W-1:0] b_idx;

  // ---------------------------------------------------------
  // AW round robin, grant locked while the request is stalled
  always_comb begin
    int idx;
    pick = rr_q;
    for (int i = int'(NUM_GEN) - 1; i >= 0; i--) begin
      idx = (int'(rr_q) + i) % int'(NUM_GEN);
      if (s_awvalid_i[idx]) begin
        pick = IDX_W'(idx);
      end
    end
  end

  assign grant       = hold_q ? hold_idx_q : pick;
  assign m_awvalid_o = s_awvalid_i[grant] && !q_full;
  assign aw_fire     = m_awvalid_o && m_awready_i;

  always_comb begin
    m_aw_o    = s_aw_i[grant];
    m_aw_o.id = {grant, s_aw_i[grant].id[GEN_ID_W-1:0]};
    for (int g = 0; g < NUM_GEN; g++) begin
      s_awready_o[g] = m_awready_i && !q_full && (grant == IDX_W'(g));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rr_q   <= '0;
      hold_q <= 1'b0;
    end else begin
      hold_q <= m_awvalid_o && !m_awready_i;
      if (aw_fire) begin
        rr_q <= (grant == IDX_W'(NUM_GEN - 1)) ? '0 : grant + IDX_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    hold_idx_q <= grant;
  end

  // ---------------------------------------------------------
  // grant order queue, head steers W
  assign q_full     = (count_q == CNT_W'(Q_DEPTH));
  assign q_empty    = (count_q == '0);
  assign head       = q_mem[rd_ptr_q];
  assign m_wvalid_o = !q_empty && s_wvalid_i[head];
  assign m_w_o      = s_w_i[head];
  assign w_pop      = m_wvalid_o && m_wready_i && m_w_o.last;

  always_comb begin
    for (int g = 0; g < NUM_GEN; g++) begin
      s_wready_o[g] = !q_empty && m_wready_i && (head == IDX_W'(g));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (aw_fire) begin
        wr_ptr_q <= wr_ptr_q + QP_W'(1);
      end
      if (w_pop) begin
        rd_ptr_q <= rd_ptr_q + QP_W'(1);
      end
      count_q <= count_q + CNT_W'(aw_fire) - CNT_W'(w_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      q_mem[wr_ptr_q] <= grant;
    end
  end

  // ---------------------------------------------------------
  // B goes back by the index bits of its id
  assign b_idx = m_b_i.id[AXI_ID_W-1:GEN_ID_W];

  always_comb begin
    m_bready_o = 1'b0;
    for (int g = 0; g < NUM_GEN; g++) begin
      s_bvalid_o[g]   = m_bvalid_i && (b_idx == IDX_W'(g));
      s_b_o[g].id     = AXI_ID_W'(m_b_i.id[GEN_ID_W-1:0]);
      s_b_o[g].resp   = m_b_i.resp;
      if (b_idx == IDX_W'(g)) begin
        m_bready_o = s_bready_i[g];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/axi_perf_stats.sv */
`default_nettype none

module axi_perf_stats (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stat_clear_i,
  input  logic                    active_i,
  input  logic                    awvalid_i,
  input  logic                    awready_i,
  input  logic                    wvalid_i,
  input  logic                    wready_i,
  input  logic                    bvalid_i,
  input  logic                    bready_i,
  input  logic [1:0]              bresp_i,
  output axi_perf_pkg::wr_stats_t stats_o
);
  import axi_perf_pkg::*;

  logic aw_fire;
  logic w_fire;
  logic b_fire;

  assign aw_fire = awvalid_i && awready_i;
  assign w_fire  = wvalid_i && wready_i;
  assign b_fire  = bvalid_i && bready_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stats_o <= '0;
    end else if (stat_clear_i) begin
      stats_o <= '0;
    end else begin
      if (aw_fire) begin
        stats_o.aw_count <= stats_o.aw_count + STAT_W'(1);
      end
      if (w_fire) begin
        stats_o.w_count <= stats_o.w_count + STAT_W'(1);
      end
      if (b_fire) begin
        stats_o.b_count <= stats_o.b_count + STAT_W'(1);
      end
      // anything but OKAY counts as an error
      if (b_fire && (bresp_i != AXI_RESP_OKAY)) begin
        stats_o.b_err_count <= stats_o.b_err_count + STAT_W'(1);
      end
      if (active_i) begin
        stats_o.active_cycles <= stats_o.active_cycles + STAT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/axi_perf.sv */
`default_nettype none

module axi_perf #(
  parameter int unsigned NUM_GEN = 2,
  localparam int unsigned SEL_W = (NUM_GEN > 1) ? $clog2(NUM_GEN) : 1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cfg_we_i,
  input  logic [SEL_W-1:0]         cfg_gen_i,
  input  axi_perf_pkg::burst_cfg_t cfg_i,
  input  logic                     start_i,
  output logic                     busy_o,
  output logic                     done_o,
  output logic                     m_awvalid_o,
  output axi_perf_pkg::axi_aw_t    m_aw_o,
  input  logic                     m_awready_i,
  output logic                     m_wvalid_o,
  output axi_perf_pkg::axi_w_t     m_w_o,
  input  logic                     m_wready_i,
  input  logic                     m_bvalid_i,
  input  axi_perf_pkg::axi_b_t     m_b_i,
  output logic                     m_bready_o,
  output axi_perf_pkg::wr_stats_t  stats_o
);
  import axi_perf_pkg::*;

  logic [NUM_GEN-1:0]       gen_start;
  logic [NUM_GEN-1:0]       gen_busy;
  burst_cfg_t [NUM_GEN-1:0] gen_cfg;
  logic                     stat_clear;

  logic [NUM_GEN-1:0]       g_awvalid;
  axi_aw_t [NUM_GEN-1:0]    g_aw;
  logic [NUM_GEN-1:0]       g_awready;
  logic [NUM_GEN-1:0]       g_wvalid;
  axi_w_t [NUM_GEN-1:0]     g_w;
  logic [NUM_GEN-1:0]       g_wready;
  logic [NUM_GEN-1:0]       g_bvalid;
  axi_b_t [NUM_GEN-1:0]     g_b;
  logic [NUM_GEN-1:0]       g_bready;

  axi_perf_ctrl #(
    .NUM_GEN(NUM_GEN)
  ) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_gen_i   (cfg_gen_i),
    .cfg_i       (cfg_i),
    .start_i     (start_i),
    .gen_busy_i  (gen_busy),
    .gen_start_o (gen_start),
    .gen_cfg_o   (gen_cfg),
    .stat_clear_o(stat_clear),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  for (genvar g = 0; g < NUM_GEN; g++) begin : gen_wr
    axi_perf_wr u_wr (
      .clk      (clk),
      .rst_n    (rst_n),
      .start_i  (gen_start[g]),
      .cfg_i    (gen_cfg[g]),
      .busy_o   (gen_busy[g]),
      .awvalid_o(g_awvalid[g]),
      .aw_o     (g_aw[g]),
      .awready_i(g_awready[g]),
      .wvalid_o (g_wvalid[g]),
      .w_o      (g_w[g]),
      .wready_i (g_wready[g]),
      .bvalid_i (g_bvalid[g]),
      .b_i      (g_b[g]),
      .bready_o (g_bready[g])
    );
  end

  axi_perf_wr_arb #(
    .NUM_GEN(NUM_GEN)
  ) u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_awvalid_i(g_awvalid),
    .s_aw_i     (g_aw),
    .s_awready_o(g_awready),
    .s_wvalid_i (g_wvalid),
    .s_w_i      (g_w),
    .s_wready_o (g_wready),
    .s_bvalid_o (g_bvalid),
    .s_b_o      (g_b),
    .s_bready_i (g_bready),
    .m_awvalid_o(m_awvalid_o),
    .m_aw_o     (m_aw_o),
    .m_awready_i(m_awready_i),
    .m_wvalid_o (m_wvalid_o),
    .m_w_o      (m_w_o),
    .m_wready_i (m_wready_i),
    .m_bvalid_i (m_bvalid_i),
    .m_b_i      (m_b_i),
    .m_bready_o (m_bready_o)
  );

  // counts are taken on the merged manager port
  axi_perf_stats u_stats (
    .clk         (clk),
    .rst_n       (rst_n),
    .stat_clear_i(stat_clear),
    .active_i    (busy_o),
    .awvalid_i   (m_awvalid_o),
    .awready_i   (m_awready_i),
    .wvalid_i    (m_wvalid_o),
    .wready_i    (m_wready_i),
    .bvalid_i    (m_bvalid_i),
    .bready_i    (m_bready_o),
    .bresp_i     (m_b_i.resp),
    .stats_o     (stats_o)
  );

endmodule

`default_nettype wire

/* sim/axi_perf_properties.sv */
`default_nettype none

module axi_perf_properties (
  input wire                   clk,
  input wire                   rst_n,
  input wire                   m_awvalid_o,
  input axi_perf_pkg::axi_aw_t m_aw_o,
  input wire                   m_awready_i,
  input wire                   m_wvalid_o,
  input axi_perf_pkg::axi_w_t  m_w_o,
  input wire                   m_wready_i,
  input wire                   busy_o,
  input wire                   done_o
);
  import axi_perf_pkg::*;

  logic [31:0] aw_cnt;
  logic [31:0] last_cnt;
  int unsigned fail_count = 0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_cnt   <= '0;
      last_cnt <= '0;
    end else begin
      aw_cnt   <= aw_cnt + 32'(m_awvalid_o && m_awready_i);
      last_cnt <= last_cnt + 32'(m_wvalid_o && m_wready_i && m_w_o.last);
    end
  end

  // ----------------------------------------------------------
  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_aw_o))
    else begin
      $error("aw valid or payload changed before ready");
      fail_count++;
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_w_o))
    else begin
      $error("w valid or payload changed before ready");
      fail_count++;
    end

  busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(busy_o && done_o))
    else begin
      $error("busy and done high together");
      fail_count++;
    end

  // a last beat needs an address that was already accepted
  last_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
    m_wvalid_o && m_wready_i && m_w_o.last |-> last_cnt < aw_cnt)
    else begin
      $error("more last beats than aw handshakes");
      fail_count++;
    end

endmodule

bind axi_perf axi_perf_properties u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .m_awvalid_o(m_awvalid_o),
  .m_aw_o     (m_aw_o),
  .m_awready_i(m_awready_i),
  .m_wvalid_o (m_wvalid_o),
  .m_w_o      (m_w_o),
  .m_wready_i (m_wready_i),
  .busy_o     (busy_o),
  .done_o     (done_o)
);

`default_nettype wire

/* sim/axi_perf_tb.sv */
`default_nettype none

module axi_perf_tb;
  import axi_perf_pkg::*;

  // three runs of at most 2048 beats, with ready stalls about a quarter of the time
  localparam int TIMEOUT_CYCLES = 20000;

  logic clk;
  logic rst_n;
  logic cfg_we_i;
  logic [0:0] cfg_gen_i;
  burst_cfg_t cfg_i;
  logic start_i;
  logic busy_o;
  logic done_o;
  logic m_awvalid_o;
  axi_aw_t m_aw_o;
  logic m_awready_i;
  logic m_wvalid_o;
  axi_w_t m_w_o;
  logic m_wready_i;
  logic m_bvalid_i;
  axi_b_t m_b_i;
  logic m_bready_o;
  wr_stats_t stats_o;

  integer seed = 32'ha07f9d3c;
  int cycles = 0;
  int errors = 0;
  int failed_tests = 0;
  burst_cfg_t exp_cfg [2];
  int aw_k [2];
  int beat = 0;
  int resp_n = 0;
  int err_inj = 0;
  int busy_cycles = 0;
  axi_aw_t aw_q [$];
  axi_b_t b_q [$];

  axi_perf #(
    .NUM_GEN(2)
  ) uut (
    .clk(clk), .rst_n(rst_n), .cfg_we_i(cfg_we_i), .cfg_gen_i(cfg_gen_i), .cfg_i(cfg_i),
    .start_i(start_i), .busy_o(busy_o), .done_o(done_o),
    .m_awvalid_o(m_awvalid_o), .m_aw_o(m_aw_o), .m_awready_i(m_awready_i),
    .m_wvalid_o(m_wvalid_o), .m_w_o(m_w_o), .m_wready_i(m_wready_i),
    .m_bvalid_i(m_bvalid_i), .m_b_i(m_b_i), .m_bready_o(m_bready_o), .stats_o(stats_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: no done after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // memory-side responder and scoreboard
  always @(negedge clk) begin
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    int g;
    logic [AXI_ADDR_W-1:0] exp_addr;
    logic [AXI_DATA_W-1:0] exp_data;
    axi_aw_t exp_aw;
    axi_b_t rsp;
    aw_hs = m_awvalid_o && m_awready_i;
    w_hs = m_wvalid_o && m_wready_i;
    b_hs = m_bvalid_i && m_bready_o;
    if (busy_o) begin
      busy_cycles++;
    end
    if (rst_n) begin
      assert (!m_bready_o || busy_o)
      else begin
        $display("CHECK FAILED t=%0t: bready high while no run is busy", $time);
        errors++;
      end
    end
    if (aw_hs) begin
      g = int'(m_aw_o.id[AXI_ID_W-1]);
      exp_addr = exp_cfg[g].base_addr + AXI_ADDR_W'(aw_k[g]) * exp_cfg[g].stride;
      assert (m_aw_o.burst == 2'd1 && m_aw_o.size == 3'd1 &&
              m_aw_o.len == exp_cfg[g].beats - 8'd1 && m_aw_o.addr == exp_addr)
      else begin
        $display("CHECK FAILED t=%0t: gen %0d burst %0d aw addr %h len %0d, expected %h len %0d",
                 $time, g, aw_k[g], m_aw_o.addr, m_aw_o.len, exp_addr, exp_cfg[g].beats - 1);
        errors++;
      end
      aw_k[g]++;
      exp_aw = m_aw_o;
      exp_aw.addr = exp_addr;
      exp_aw.len = exp_cfg[g].beats - 8'd1;
      aw_q.push_back(exp_aw);
    end
    if (w_hs) begin
      if (aw_q.size() == 0) begin
        $display("t=%0t: a W beat arrived before any accepted AW request", $time);
        errors++;
      end else begin
        exp_data = AXI_DATA_W'(aw_q[0].addr) + AXI_DATA_W'(2 * beat);
        assert (m_w_o.data == exp_data && m_w_o.strb == '1 &&
                m_w_o.last == (beat == int'(aw_q[0].len)))
        else begin
          $display("CHECK FAILED t=%0t: beat %0d of burst %h data %h last %b, expected %h",
                   $time, beat, aw_q[0].addr, m_w_o.data, m_w_o.last, exp_data);
          errors++;
        end
        if (beat == int'(aw_q[0].len)) begin
          resp_n++;
          rsp.id = aw_q[0].id;
          rsp.resp = AXI_RESP_OKAY;
          // every fifth response is SLVERR
          if (resp_n % 5 == 0) begin
            rsp.resp = 2'b10;
            err_inj++;
          end
          b_q.push_back(rsp);
          void'(aw_q.pop_front());
          beat = 0;
        end else begin
          beat++;
        end
      end
    end
    if (b_hs) begin
      void'(b_q.pop_front());
    end
    @(posedge clk);
    #2;
    m_awready_i = ($random(seed) & 3) != 0;
    m_wready_i = ($random(seed) & 3) != 0;
    if (b_hs) begin
      m_bvalid_i = 1'b0;
    end
    if (b_q.size() > 0 && !m_bvalid_i) begin
      m_bvalid_i = ($random(seed) & 1) != 0;
    end
    if (b_q.size() > 0) begin
      m_b_i = b_q[0];
    end
  end

  // ----------------------------------------------------------
  task automatic write_cfg(input int gen, input burst_cfg_t cfg);
    @(posedge clk);
    #2;
    cfg_we_i = 1'b1;
    cfg_gen_i = gen[0:0];
    cfg_i = cfg;
    @(posedge clk);
    #2;
    cfg_we_i = 1'b0;
  endtask

  task automatic run_test(input int num, input logic write_in_busy);
    int err_before;
    int total_bursts;
    int total_beats;
    burst_cfg_t junk;
    err_before = errors;
    aw_k[0] = 0;
    aw_k[1] = 0;
    err_inj = 0;
    busy_cycles = 0;
    @(posedge clk);
    #2;
    start_i = 1'b1;
    @(posedge clk);
    #2;
    start_i = 1'b0;
    assert (busy_o && !done_o)
    else begin
      $display("CHECK FAILED t=%0t: busy not high one cycle after start", $time);
      errors++;
    end
    if (write_in_busy) begin
      junk = '{base_addr: 20'hfff00, beats: 8'd3, stride: 20'h10, num_bursts: 16'd2};
      write_cfg(0, junk);
      write_cfg(1, junk);
    end
    while (!done_o) begin
      @(negedge clk);
    end
    total_bursts = exp_cfg[0].num_bursts + exp_cfg[1].num_bursts;
    total_beats = exp_cfg[0].num_bursts * exp_cfg[0].beats +
                  exp_cfg[1].num_bursts * exp_cfg[1].beats;
    assert (stats_o.aw_count == total_bursts && stats_o.b_count == total_bursts &&
            stats_o.w_count == total_beats && stats_o.b_err_count == err_inj &&
            stats_o.active_cycles == busy_cycles - 1)
    else begin
      $display("CHECK FAILED t=%0t: stats aw %0d w %0d b %0d err %0d act %0d", $time,
               stats_o.aw_count, stats_o.w_count, stats_o.b_count, stats_o.b_err_count,
               stats_o.active_cycles);
      errors++;
    end
    assert (aw_k[0] == exp_cfg[0].num_bursts && aw_k[1] == exp_cfg[1].num_bursts)
    else begin
      $display("CHECK FAILED t=%0t: burst counts %0d and %0d", $time, aw_k[0], aw_k[1]);
      errors++;
    end
    if (errors != err_before) begin
      failed_tests++;
    end
    $display("test %0d: %s (%0d errors)", num, (errors == err_before) ? "ok" : "failed",
             errors - err_before);
  endtask

  // ----------------------------------------------------------
  initial begin
    burst_cfg_t c0;
    burst_cfg_t c1;
    rst_n = 1'b0;
    cfg_we_i = 1'b0;
    cfg_gen_i = '0;
    cfg_i = CFG_RESET;
    start_i = 1'b0;
    m_awready_i = 1'b0;
    m_wready_i = 1'b0;
    m_bvalid_i = 1'b0;
    m_b_i = '0;
    exp_cfg[0] = '{base_addr: '0, beats: 8'd64, stride: 20'd256, num_bursts: 16'd16};
    exp_cfg[1] = exp_cfg[0];
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    run_test(1, 1'b0);

    c0 = '{base_addr: 20'h01000, beats: 8'd8, stride: 20'h040, num_bursts: 16'd10};
    c1 = '{base_addr: 20'h08000, beats: 8'd16, stride: 20'h100, num_bursts: 16'd6};
    write_cfg(0, c0);
    write_cfg(1, c1);
    exp_cfg[0] = c0;
    exp_cfg[1] = c1;
    run_test(2, 1'b1);

    // writes during run two were dropped so its settings still hold
    run_test(3, 1'b0);

    $display("tests: 3, failed tests: %0d, failed checks: %0d, property failures: %0d",
             failed_tests, errors, uut.u_props.fail_count);
    if (errors == 0 && uut.u_props.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rtl/axi_perf_pkg.sv
rtl/axi_perf_ctrl.sv
rtl/axi_perf_wr.sv
rtl/axi_perf_wr_arb.sv
rtl/axi_perf_stats.sv
rtl/axi_perf.sv
sim/axi_perf_properties.sv
sim/axi_perf_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= axi_perf_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
